// File: run.sh
#!/bin/sh
# Build and run the AHB command slave testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_ahb_cmd_slave
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: no errors" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: testbench/ahb_cmd_slave_props.sv
// Slave interface and decoder checks
module ahb_cmd_slave_props
    import ahb_pkg::*;
    import map_pkg::*;
(
    input logic     hclk,
    input logic     reset,
    input ahb_req_t req,
    input logic     hready,
    input decode_t  decode,
    input logic     reg_write,
    input logic     cmd_write
);

    logic write_accept;

    // Address phase that carries a write into the slave
    assign write_accept = hready && req.sel && req.write &&
                          (req.trans == NONSEQ || req.trans == SEQ);

    // ------------------------------------------------------------
    // Decoder and strobe properties
    // ------------------------------------------------------------

    // The decoder never selects both stores at once
    select_exclusive: assert property (@(posedge hclk) disable iff (reset)
        !(decode.reg_en && decode.cmd_en))
        else $error("register and command selects are high together");

    // A strobe is high only in the cycle after an accepted write address phase
    strobe_after_write: assert property (@(posedge hclk) disable iff (reset)
        (reg_write || cmd_write) |-> $past(write_accept))
        else $error("write strobe without an accepted write in the previous cycle");

endmodule

// The decoder result reaches the slave interface on its decode port
bind ahb_slave_if ahb_cmd_slave_props u_ahb_cmd_slave_props (
    .hclk      (hclk),
    .reset     (reset),
    .req       (req),
    .hready    (hready),
    .decode    (decode),
    .reg_write (reg_write),
    .cmd_write (cmd_write)
);

// File: testbench/tb_ahb_cmd_slave.sv
// AHB command slave testbench
module tb_ahb_cmd_slave
    import ahb_pkg::*;
    import map_pkg::*;
;

    localparam int DATA_WIDTH   = 32;
    localparam int RESET_CYCLES = 16;
    // Register pass and buffer write-then-read sweep
    localparam int N_DIRECTED   = 8 + 512;
    localparam int N_RANDOM     = 3000;
    localparam int CYCLE_LIMIT  = 2 * (N_DIRECTED + N_RANDOM) + RESET_CYCLES;

    logic                  hclk = 1'b0;
    logic                  reset;
    ahb_req_t              req;
    logic                  hready;
    logic [DATA_WIDTH-1:0] hwdata;
    logic [DATA_WIDTH-1:0] hrdata;
    logic [DATA_WIDTH-1:0] ctrl;

    // Model of the four registers and the command buffer
    logic [31:0]  regs_model [4];
    logic [31:0]  cmd_model [256];
    logic [255:0] cmd_written = '0;
    logic [31:0]  exp_ctrl = '0;
    logic [31:0]  rng = 32'hfbfb;

    // Write pending for the next data phase, and the read phase under way
    logic         pend_write = 1'b0;
    logic [31:0]  pend_addr = '0;
    logic         dp_read = 1'b0;
    logic         dp_known = 1'b0;
    logic [31:0]  dp_addr = '0;
    logic [31:0]  dp_data = '0;
    // Copies for the compare process, updated one step late
    logic         chk_valid = 1'b0;
    logic [31:0]  chk_addr = '0;
    logic [31:0]  chk_data = '0;
    logic         check_on = 1'b0;
    int           errors = 0;
    int           read_checks = 0;
    int           ctrl_checks = 0;
    int           cycle_count = 0;

    always #2 hclk = ~hclk;

    ahb_cmd_slave #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_ahb_cmd_slave (
        .hclk   (hclk),
        .reset  (reset),
        .req    (req),
        .hready (hready),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .ctrl   (ctrl)
    );

    // ------------------------------------------------------------
    // Stimulus helpers and reference model
    // ------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic ahb_req_t build_req(input logic write, input logic [8:0] idx);
        ahb_req_t r;
        r.sel   = 1'b1;
        r.trans = NONSEQ;
        r.write = write;
        r.addr  = {21'd0, idx, 2'b00};
        return r;
    endfunction

    // Expected read word from the register map, known is low for unwritten buffer words
    function automatic logic [31:0] expected_word(input logic [31:0] addr, output logic known);
        logic [8:0] idx;
        logic [7:0] off;
        idx   = addr[10:2];
        off   = 8'(idx - 9'd4);
        known = 1'b1;
        if (addr[1:0] != 2'b00 || idx >= 9'd260) begin
            return '0;
        end else if (idx < 9'd4) begin
            return regs_model[idx[1:0]];
        end
        known = cmd_written[off];
        return cmd_model[off];
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [31:0] data);
        logic [8:0] idx;
        logic [7:0] off;
        idx = addr[10:2];
        off = 8'(idx - 9'd4);
        if (addr[1:0] == 2'b00 && idx < 9'd4) begin
            // Word 3 is the status count and ignores bus writes
            if (idx[1:0] != 2'd3) begin
                regs_model[idx[1:0]] = data;
            end
            if (idx[1:0] == 2'd0) begin
                exp_ctrl <= data;
            end
        end else if (addr[1:0] == 2'b00 && idx < 9'd260) begin
            cmd_model[off]   = data;
            cmd_written[off] = 1'b1;
            regs_model[3]    = regs_model[3] + 32'd1;
        end
    endtask

    // One clock of bus activity: data for the last accepted write, then a new address phase
    task automatic bus_cycle(input ahb_req_t r, input logic rdy);
        logic known;
        logic acc;
        @(negedge hclk);
        rng    = xorshift32(rng);
        hwdata = rng;
        if (pend_write) begin
            model_write(pend_addr, rng);
        end
        req    = r;
        hready = rdy;
        acc    = rdy && r.sel && (r.trans == NONSEQ || r.trans == SEQ);
        pend_write = acc && r.write;
        pend_addr  = r.addr;
        // Low hready keeps the data phase that is under way
        if (rdy) begin
            dp_read  = acc && !r.write;
            dp_addr  = r.addr;
            dp_data  = expected_word(r.addr, known);
            dp_known = known;
        end
        chk_valid <= dp_read && dp_known;
        chk_addr  <= dp_addr;
        chk_data  <= dp_data;
    endtask

    // Mix of register, buffer, unmapped, unaligned and repeated addresses
    task automatic random_transfer(output ahb_req_t r, output logic rdy);
        logic [31:0] a;
        logic [31:0] b;
        logic [8:0]  idx;
        rng = xorshift32(rng);
        a   = rng;
        rng = xorshift32(rng);
        b   = rng;
        case (a[2:0])
            3'd0, 3'd1:       idx = {7'd0, a[9:8]};
            3'd2, 3'd3, 3'd4: idx = 9'd4 + {1'b0, a[15:8]};
            3'd5:             idx = 9'd260 + ({1'b0, a[15:8]} % 9'd252);
            default:          idx = a[16:8];
        endcase
        r = build_req(b[8], idx);
        if (a[2:0] == 3'd6) begin
            r.addr[1:0] = (a[18:17] == 2'b00) ? 2'b11 : a[18:17];
        end else if (a[2:0] == 3'd7) begin
            r.addr = pend_addr;
        end
        r.sel   = (b[3:0] != 4'd0);
        r.trans = (b[6:4] == 3'd0) ? IDLE : (b[6:4] == 3'd1) ? BUSY : (b[7] ? SEQ : NONSEQ);
        rdy     = (b[12:10] != 3'd0);
    endtask

    // ------------------------------------------------------------
    // Compare, driver and run limit
    // ------------------------------------------------------------

    // Outputs come from registered state, so the falling edge sees them settled
    always @(negedge hclk) begin
        if (check_on) begin
            ctrl_checks++;
            assert (ctrl === exp_ctrl) else begin
                $display("error: time %0t ctrl expected %h got %h", $time, exp_ctrl, ctrl);
                errors++;
            end
            if (chk_valid) begin
                read_checks++;
                assert (hrdata === chk_data) else begin
                    $display("error: time %0t hrdata addr %h expected %h got %h",
                             $time, chk_addr, chk_data, hrdata);
                    errors++;
                end
            end
        end
    end

    initial begin
        ahb_req_t r;
        logic     rdy;
        req    = '0;
        hready = 1'b1;
        hwdata = '0;
        reset  = 1'b1;
        for (int i = 0; i < 4; i++) begin
            regs_model[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge hclk);
        reset = 1'b0;
        check_on <= 1'b1;
        // Every register, status included, written then read back
        for (int i = 0; i < 4; i++) begin
            bus_cycle(build_req(1'b1, 9'(i)), 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            bus_cycle(build_req(1'b0, 9'(i)), 1'b1);
        end
        // Each buffer word written and read straight after
        for (int i = 4; i < 260; i++) begin
            bus_cycle(build_req(1'b1, 9'(i)), 1'b1);
            bus_cycle(build_req(1'b0, 9'(i)), 1'b1);
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            random_transfer(r, rdy);
            bus_cycle(r, rdy);
        end
        repeat (3) bus_cycle('0, 1'b1);
        @(posedge hclk);
        $display("Checks: %0d hrdata, %0d ctrl, errors: %0d", read_checks, ctrl_checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge hclk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: verilog/address_decoder.sv
// Slave address decoder
module address_decoder
    import ahb_pkg::*;
    import map_pkg::*;
(
    input  logic [ADDR_WIDTH-1:0] slv_o_addr,
    output decode_t               decode
);

    // Register file occupies word indices 0 to 3
    localparam logic [8:0] REG_WORDS = 9'd4;
    // Command buffer ends just below word index 260
    localparam logic [8:0] CMD_END   = 9'd260;

    logic [8:0] word_idx;
    logic [8:0] cmd_idx;
    logic       aligned;
    region_t    region;

    // Word index taken from address bits 10 down to 2
    assign word_idx = slv_o_addr[10:2];
    // Only word transfers are mapped, so the byte lane bits must be zero
    assign aligned  = (slv_o_addr[1:0] == 2'b00);
    // Buffer offset counts from the first word after the registers
    assign cmd_idx  = word_idx - REG_WORDS;

    // ------------------------------------------------------------
    // Region select
    // ------------------------------------------------------------

    always_comb begin
        if (!aligned) begin
            region = NO_REGION;
        end else if (word_idx < REG_WORDS) begin
            region = REG_REGION;
        end else if (word_idx < CMD_END) begin
            region = CMD_REGION;
        end else begin
            region = NO_REGION;
        end
    end

    // ------------------------------------------------------------
    // Selects and offset
    // ------------------------------------------------------------

    always_comb begin
        // Unmapped addresses give no select and a zero offset
        decode = '0;
        case (region)
            REG_REGION: begin
                decode.reg_en     = 1'b1;
                decode.trans_addr = TRANS_ADDR_WIDTH'(word_idx[1:0]);
            end
            CMD_REGION: begin
                decode.cmd_en     = 1'b1;
                decode.trans_addr = cmd_idx[TRANS_ADDR_WIDTH-1:0];
            end
            default: begin
                decode = '0;
            end
        endcase
    end

endmodule

// File: verilog/ahb_cmd_slave.sv
// AHB-lite command slave top level
module ahb_cmd_slave
    import ahb_pkg::*;
    import map_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  hclk,
    input  logic                  reset,
    input  ahb_req_t              req,
    input  logic                  hready,
    input  logic [DATA_WIDTH-1:0] hwdata,
    output logic [DATA_WIDTH-1:0] hrdata,
    output logic [DATA_WIDTH-1:0] ctrl
);

    logic [ADDR_WIDTH-1:0] slv_o_addr;
    decode_t               decode;
    logic                  reg_write;
    logic                  cmd_write;
    logic [DATA_WIDTH-1:0] wdata;
    logic [DATA_WIDTH-1:0] reg_rdata;
    logic [DATA_WIDTH-1:0] cmd_rdata;

    // ------------------------------------------------------------
    // Bus side and decode
    // ------------------------------------------------------------

    ahb_slave_if #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_ahb_slave_if (
        .hclk       (hclk),
        .reset      (reset),
        .req        (req),
        .hready     (hready),
        .hwdata     (hwdata),
        .decode     (decode),
        .reg_rdata  (reg_rdata),
        .cmd_rdata  (cmd_rdata),
        .slv_o_addr (slv_o_addr),
        .reg_write  (reg_write),
        .cmd_write  (cmd_write),
        .wdata      (wdata),
        .hrdata     (hrdata)
    );

    address_decoder u_address_decoder (
        .slv_o_addr (slv_o_addr),
        .decode     (decode)
    );

    // ------------------------------------------------------------
    // Stores
    // ------------------------------------------------------------

    // Registers only see the low two offset bits
    register_file #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_register_file (
        .hclk      (hclk),
        .reset     (reset),
        .write     (reg_write),
        .addr      (decode.trans_addr[1:0]),
        .wdata     (wdata),
        .cmd_write (cmd_write),
        .rdata     (reg_rdata),
        .ctrl      (ctrl)
    );

    command_buffer #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_command_buffer (
        .hclk  (hclk),
        .write (cmd_write),
        .addr  (decode.trans_addr),
        .wdata (wdata),
        .rdata (cmd_rdata)
    );

endmodule

// File: verilog/ahb_pkg.sv
// AHB-lite bus types
package ahb_pkg;

    // ------------------------------------------------------------
    // Bus geometry
    // ------------------------------------------------------------

    // Address bus width is fixed because the memory map is tied to it
    localparam int ADDR_WIDTH = 32;

    // ------------------------------------------------------------
    // Transfer type
    // ------------------------------------------------------------

    // Encoding follows the AHB htrans field
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // ------------------------------------------------------------
    // Address phase request
    // ------------------------------------------------------------

    // One address phase as driven by the master and the interconnect
    typedef struct packed {
        // Slave select from the interconnect
        logic                  sel;
        // Transfer type, only NONSEQ and SEQ carry a transfer
        htrans_t               trans;
        // High for a write, low for a read
        logic                  write;
        // Byte address of the transfer
        logic [ADDR_WIDTH-1:0] addr;
    } ahb_req_t;

endpackage

// File: verilog/ahb_slave_if.sv
// AHB-lite slave bus interface
module ahb_slave_if
    import ahb_pkg::*;
    import map_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  hclk,
    input  logic                  reset,
    input  ahb_req_t              req,
    input  logic                  hready,
    input  logic [DATA_WIDTH-1:0] hwdata,
    input  decode_t               decode,
    input  logic [DATA_WIDTH-1:0] reg_rdata,
    input  logic [DATA_WIDTH-1:0] cmd_rdata,
    output logic [ADDR_WIDTH-1:0] slv_o_addr,
    output logic                  reg_write,
    output logic                  cmd_write,
    output logic [DATA_WIDTH-1:0] wdata,
    output logic [DATA_WIDTH-1:0] hrdata
);

    logic accept;
    logic write_q;
    logic first_q;
    logic data_phase;

    // ------------------------------------------------------------
    // Address phase
    // ------------------------------------------------------------

    // A transfer needs the slave selected, an active type and the bus ready
    assign accept = hready && req.sel && (req.trans == NONSEQ || req.trans == SEQ);

    always_ff @(posedge hclk) begin
        if (reset) begin
            slv_o_addr <= '0;
            write_q    <= 1'b0;
            first_q    <= 1'b0;
            data_phase <= 1'b0;
        end else begin
            // High only in the first cycle after an accepted address phase
            first_q <= accept;
            // Low hready stretches the data phase that is under way
            if (hready) begin
                data_phase <= accept;
            end
            // Address and direction stay put until the next accepted transfer
            if (accept) begin
                slv_o_addr <= req.addr;
                write_q    <= req.write;
            end
        end
    end

    // ------------------------------------------------------------
    // Data phase writes
    // ------------------------------------------------------------

    // Strobes fire once per write, and unmapped writes raise neither one
    assign reg_write = first_q && write_q && decode.reg_en;
    assign cmd_write = first_q && write_q && decode.cmd_en;

    // Write data comes straight from the bus in the data phase
    assign wdata = hwdata;

    // ------------------------------------------------------------
    // Read data
    // ------------------------------------------------------------

    always_comb begin
        if (data_phase && decode.reg_en) begin
            hrdata = reg_rdata;
        end else if (data_phase && decode.cmd_en) begin
            hrdata = cmd_rdata;
        end else begin
            // Unmapped reads and idle cycles return zero
            hrdata = '0;
        end
    end

endmodule

// File: verilog/command_buffer.sv
// Command word buffer
module command_buffer
    import map_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic                        hclk,
    input  logic                        write,
    input  logic [TRANS_ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0]       wdata,
    output logic [DATA_WIDTH-1:0]       rdata
);

    // One entry per offset value, 256 words
    localparam int DEPTH = 1 << TRANS_ADDR_WIDTH;

    // Storage has no reset so it can map onto block memory
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // ------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------

    // Written at the edge that ends the data phase
    always_ff @(posedge hclk) begin
        if (write) begin
            mem[addr] <= wdata;
        end
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------

    // Combinational read, so a write is visible to the next data phase
    assign rdata = mem[addr];

endmodule

// File: verilog/map_pkg.sv
// Slave memory map types
package map_pkg;

    // ------------------------------------------------------------
    // Regions and offsets
    // ------------------------------------------------------------

    // The region that a registered address falls into
    typedef enum logic [1:0] {
        REG_REGION = 2'd0,
        CMD_REGION = 2'd1,
        NO_REGION  = 2'd2
    } region_t;

    // Offset width inside a region, wide enough for the 256 word buffer
    localparam int TRANS_ADDR_WIDTH = 8;

    // ------------------------------------------------------------
    // Register indices
    // ------------------------------------------------------------

    // Control word, its value leaves the subsystem as ctrl
    localparam logic [1:0] REG_CTRL     = 2'd0;
    // Two general purpose scratch words
    localparam logic [1:0] REG_SCRATCH0 = 2'd1;
    localparam logic [1:0] REG_SCRATCH1 = 2'd2;
    // Read-only count of command buffer writes
    localparam logic [1:0] REG_STATUS   = 2'd3;

    // ------------------------------------------------------------
    // Decoder result
    // ------------------------------------------------------------

    // At most one of the two selects is high
    typedef struct packed {
        logic                        reg_en;
        logic                        cmd_en;
        logic [TRANS_ADDR_WIDTH-1:0] trans_addr;
    } decode_t;

endpackage

// File: verilog/register_file.sv
// Control, scratch and status registers
module register_file
    import map_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  hclk,
    input  logic                  reset,
    input  logic                  write,
    input  logic [1:0]            addr,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic                  cmd_write,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic [DATA_WIDTH-1:0] ctrl
);

    logic [DATA_WIDTH-1:0] ctrl_q;
    logic [DATA_WIDTH-1:0] scratch0_q;
    logic [DATA_WIDTH-1:0] scratch1_q;
    logic [DATA_WIDTH-1:0] cmd_count_q;

    // ------------------------------------------------------------
    // Register updates
    // ------------------------------------------------------------

    always_ff @(posedge hclk) begin
        if (reset) begin
            ctrl_q      <= '0;
            scratch0_q  <= '0;
            scratch1_q  <= '0;
            cmd_count_q <= '0;
        end else begin
            if (write && addr == REG_CTRL) begin
                ctrl_q <= wdata;
            end
            if (write && addr == REG_SCRATCH0) begin
                scratch0_q <= wdata;
            end
            if (write && addr == REG_SCRATCH1) begin
                scratch1_q <= wdata;
            end
            // Counts at the same edge as the buffer write, bus writes are ignored
            if (cmd_write) begin
                cmd_count_q <= cmd_count_q + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------

    always_comb begin
        case (addr)
            REG_CTRL:     rdata = ctrl_q;
            REG_SCRATCH0: rdata = scratch0_q;
            REG_SCRATCH1: rdata = scratch1_q;
            REG_STATUS:   rdata = cmd_count_q;
            default:      rdata = '0;
        endcase
    end

    // The control word drives the subsystem output directly
    assign ctrl = ctrl_q;

endmodule

// File: vlog.f
verilog/ahb_pkg.sv
verilog/map_pkg.sv
verilog/address_decoder.sv
verilog/ahb_slave_if.sv
verilog/register_file.sv
verilog/command_buffer.sv
verilog/ahb_cmd_slave.sv
testbench/ahb_cmd_slave_props.sv
testbench/tb_ahb_cmd_slave.sv
